// File: hw/router_cfg_pkg.sv
// Build-time constants for the four-port echo router
// Register map is word addressed, one 32-bit register per address
package router_cfg_pkg;

    ////////////////////////////////////////
    // Datapath

    localparam int NUM_PORTS       = 4;
    localparam int DATA_BYTES      = 4;
    localparam int ING_FIFO_DEPTH  = 16;
    localparam int CORE_FIFO_DEPTH = 8;

    ////////////////////////////////////////
    // Register map

    localparam int CNT_WIDTH        = 16;
    localparam int REG_ADDR_WIDTH   = 8;
    localparam int REG_ENABLE_ADDR  = 0;
    // Counter p of each bank sits at base + p
    localparam int REG_ING_CNT_BASE = 16;
    localparam int REG_EGR_CNT_BASE = 32;

endpackage

// File: hw/router_types_pkg.sv
// Stream beat and register bus types shared by the router blocks
package router_types_pkg;

    import router_cfg_pkg::*;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // One stream beat, keep has one bit per data byte
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } beat_t;

    // Beat tagged with its egress port
    typedef struct packed {
        beat_t     beat;
        port_idx_t dest;
    } routed_beat_t;

    typedef struct packed {
        logic                      rd;
        logic                      wr;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [31:0]               wdata;
    } reg_req_t;

endpackage

// File: hw/beat_fifo.sv
// Single-clock FIFO, one push and one pop per cycle, DEPTH of two or more
// Head is read straight from the array, so a written beat shows one cycle later
module beat_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  logic phys_port_clk_ifc,
    input  logic rst,
    input  T     in_beat,
    input  logic in_valid,
    output logic in_ready,
    output T     out_beat,
    output logic out_valid,
    input  logic out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    always_ff @(posedge phys_port_clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/packet_arbiter.sv
// Round-robin over ingress FIFOs, locked on one port until its last beat leaves
// port_enable is sampled at packet start; packets of a disabled port are dropped
module packet_arbiter import router_cfg_pkg::*, router_types_pkg::*; (
    input  logic                  phys_port_clk_ifc,
    input  logic                  rst,
    input  beat_t [NUM_PORTS-1:0] fifo_beat,
    input  logic [NUM_PORTS-1:0]  fifo_valid,
    output logic [NUM_PORTS-1:0]  fifo_ready,
    input  logic [NUM_PORTS-1:0]  port_enable,
    output routed_beat_t          out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    port_idx_t grant;
    logic      locked;
    logic      dropping;

    port_idx_t rr_port;
    logic      rr_found;
    port_idx_t sel_port;
    logic      sel_valid;
    logic      sel_drop;
    logic      load_ok;
    logic      pop;

    ////////////////////////////////////////
    // Port selection

    // First requester after the last winner
    always_comb begin
        port_idx_t cand;
        rr_found = 1'b0;
        rr_port  = grant;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = port_idx_t'((int'(grant) + i) % NUM_PORTS);
            if (!rr_found && fifo_valid[cand]) begin
                rr_found = 1'b1;
                rr_port  = cand;
            end
        end
    end

    assign sel_port  = locked ? grant : rr_port;
    assign sel_valid = locked ? fifo_valid[grant] : rr_found;
    assign sel_drop  = locked ? dropping : ~port_enable[rr_port];
    assign load_ok   = ~out_valid | out_ready;
    // Dropped beats drain even while the output is stalled
    assign pop       = sel_valid & (sel_drop | load_ok);

    always_comb begin
        fifo_ready           = '0;
        fifo_ready[sel_port] = pop;
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            grant    <= port_idx_t'(NUM_PORTS - 1);
            locked   <= 1'b0;
            dropping <= 1'b0;
        end else if (pop) begin
            grant    <= sel_port;
            locked   <= ~fifo_beat[sel_port].last;
            dropping <= sel_drop;
        end
    end

    ////////////////////////////////////////
    // Output register

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load_ok) begin
            out_valid <= pop & ~sel_drop;
        end
    end

    // Echo mode, dest is the source port
    always_ff @(posedge phys_port_clk_ifc) begin
        if (load_ok && pop && !sel_drop) begin
            out_beat.beat <= fifo_beat[sel_port];
            out_beat.dest <= sel_port;
        end
    end

endmodule

// File: hw/egress_demux.sv
// Steers tagged beats from the core buffer into one output register per egress port
// A beat waits at the head while the register of its dest is full and stalled
module egress_demux import router_cfg_pkg::*, router_types_pkg::*; (
    input  logic                  phys_port_clk_ifc,
    input  logic                  rst,
    input  routed_beat_t          in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output beat_t [NUM_PORTS-1:0] egr_beat,
    output logic [NUM_PORTS-1:0]  egr_valid,
    input  logic [NUM_PORTS-1:0]  egr_ready
);

    logic                 take;
    logic [NUM_PORTS-1:0] load;

    // Register free or draining this cycle
    assign in_ready = ~egr_valid[in_beat.dest] | egr_ready[in_beat.dest];
    assign take     = in_valid & in_ready;

    always_comb begin
        load                = '0;
        load[in_beat.dest]  = take;
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            egr_valid <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!egr_valid[p] || egr_ready[p]) begin
                    egr_valid[p] <= load[p];
                end
            end
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (load[p]) begin
                egr_beat[p] <= in_beat.beat;
            end
        end
    end

endmodule

// File: hw/router_regs.sv
// Port-enable mask and per-port packet counters; unmapped reads return zero
// reg_rvalid follows a read request by exactly one cycle, writes land on the next edge
module router_regs import router_cfg_pkg::*, router_types_pkg::*; (
    input  logic                 phys_port_clk_ifc,
    input  logic                 rst,
    input  reg_req_t             reg_req,
    output logic [31:0]          reg_rdata,
    output logic                 reg_rvalid,
    input  logic [NUM_PORTS-1:0] ing_pkt_done,
    input  logic [NUM_PORTS-1:0] egr_pkt_done,
    output logic [NUM_PORTS-1:0] port_enable
);

    logic [CNT_WIDTH-1:0] ing_cnt [NUM_PORTS];
    logic [CNT_WIDTH-1:0] egr_cnt [NUM_PORTS];
    logic [31:0]          rd_data;

    ////////////////////////////////////////
    // Control and counters

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            port_enable <= '1;
        end else if (reg_req.wr && reg_req.addr == REG_ADDR_WIDTH'(REG_ENABLE_ADDR)) begin
            port_enable <= reg_req.wdata[NUM_PORTS-1:0];
        end
    end

    // Counters wrap at CNT_WIDTH
    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                ing_cnt[p] <= '0;
                egr_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (ing_pkt_done[p] && port_enable[p]) begin
                    ing_cnt[p] <= ing_cnt[p] + 1'b1;
                end
                if (egr_pkt_done[p]) begin
                    egr_cnt[p] <= egr_cnt[p] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read path

    always_comb begin
        rd_data = '0;
        if (reg_req.addr == REG_ADDR_WIDTH'(REG_ENABLE_ADDR)) begin
            rd_data[NUM_PORTS-1:0] = port_enable;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (reg_req.addr == REG_ADDR_WIDTH'(REG_ING_CNT_BASE + p)) begin
                rd_data[CNT_WIDTH-1:0] = ing_cnt[p];
            end
            if (reg_req.addr == REG_ADDR_WIDTH'(REG_EGR_CNT_BASE + p)) begin
                rd_data[CNT_WIDTH-1:0] = egr_cnt[p];
            end
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_req.rd;
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (reg_req.rd) begin
            reg_rdata <= rd_data;
        end
    end

endmodule

// File: hw/phys_port_router.sv
// Four-port echo router on one clock; each packet leaves on the port it arrived on
// Ingress FIFOs feed a packet arbiter, a shared core buffer and per-port egress registers
module phys_port_router import router_cfg_pkg::*, router_types_pkg::*; (
    input  logic                  phys_port_clk_ifc,
    input  logic                  rst,
    input  beat_t [NUM_PORTS-1:0] ing_beat,
    input  logic [NUM_PORTS-1:0]  ing_valid,
    output logic [NUM_PORTS-1:0]  ing_ready,
    output beat_t [NUM_PORTS-1:0] egr_beat,
    output logic [NUM_PORTS-1:0]  egr_valid,
    input  logic [NUM_PORTS-1:0]  egr_ready,
    input  reg_req_t              reg_req,
    output logic [31:0]           reg_rdata,
    output logic                  reg_rvalid
);

    beat_t [NUM_PORTS-1:0] fifo_beat;
    logic [NUM_PORTS-1:0]  fifo_valid;
    logic [NUM_PORTS-1:0]  fifo_ready;
    routed_beat_t          arb_beat;
    logic                  arb_valid;
    logic                  arb_ready;
    routed_beat_t          core_beat;
    logic                  core_valid;
    logic                  core_ready;
    logic [NUM_PORTS-1:0]  port_enable;
    logic [NUM_PORTS-1:0]  ing_pkt_done;
    logic [NUM_PORTS-1:0]  egr_pkt_done;

    ////////////////////////////////////////
    // Ingress

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ing
        beat_fifo #(
            .T     (beat_t),
            .DEPTH (ING_FIFO_DEPTH)
        ) u_ing_fifo (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .rst               (rst),
            .in_beat           (ing_beat[p]),
            .in_valid          (ing_valid[p]),
            .in_ready          (ing_ready[p]),
            .out_beat          (fifo_beat[p]),
            .out_valid         (fifo_valid[p]),
            .out_ready         (fifo_ready[p])
        );

        // End of packet pulses for the counters
        assign ing_pkt_done[p] = ing_valid[p] & ing_ready[p] & ing_beat[p].last;
        assign egr_pkt_done[p] = egr_valid[p] & egr_ready[p] & egr_beat[p].last;
    end

    packet_arbiter u_arbiter (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .fifo_beat         (fifo_beat),
        .fifo_valid        (fifo_valid),
        .fifo_ready        (fifo_ready),
        .port_enable       (port_enable),
        .out_beat          (arb_beat),
        .out_valid         (arb_valid),
        .out_ready         (arb_ready)
    );

    ////////////////////////////////////////
    // Core buffer and egress

    beat_fifo #(
        .T     (routed_beat_t),
        .DEPTH (CORE_FIFO_DEPTH)
    ) u_core_fifo (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .in_beat           (arb_beat),
        .in_valid          (arb_valid),
        .in_ready          (arb_ready),
        .out_beat          (core_beat),
        .out_valid         (core_valid),
        .out_ready         (core_ready)
    );

    egress_demux u_egress (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .in_beat           (core_beat),
        .in_valid          (core_valid),
        .in_ready          (core_ready),
        .egr_beat          (egr_beat),
        .egr_valid         (egr_valid),
        .egr_ready         (egr_ready)
    );

    router_regs u_regs (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .reg_req           (reg_req),
        .reg_rdata         (reg_rdata),
        .reg_rvalid        (reg_rvalid),
        .ing_pkt_done      (ing_pkt_done),
        .egr_pkt_done      (egr_pkt_done),
        .port_enable       (port_enable)
    );

endmodule

// File: tb/phys_port_router_sva.sv
// Stream handshake assertions, bound into the router top level
module phys_port_router_sva import router_cfg_pkg::*, router_types_pkg::*; (
    input logic                  phys_port_clk_ifc,
    input logic                  rst,
    input beat_t [NUM_PORTS-1:0] ing_beat,
    input logic [NUM_PORTS-1:0]  ing_valid,
    input logic [NUM_PORTS-1:0]  ing_ready,
    input beat_t [NUM_PORTS-1:0] egr_beat,
    input logic [NUM_PORTS-1:0]  egr_valid,
    input logic [NUM_PORTS-1:0]  egr_ready
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        ing_hold: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
            ing_valid[p] && !ing_ready[p] |=> ing_valid[p] && $stable(ing_beat[p]))
            else $error("Ingress port %0d changed its beat before ready", p);

        egr_hold: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
            egr_valid[p] && !egr_ready[p] |=> egr_valid[p] && $stable(egr_beat[p]))
            else $error("Egress port %0d changed its beat before ready", p);
    end

    egr_idle_after_reset: assert property (@(posedge phys_port_clk_ifc)
        rst |=> egr_valid == '0)
        else $error("Egress valid high in the cycle after reset");

endmodule

bind phys_port_router phys_port_router_sva u_sva (
    .phys_port_clk_ifc (phys_port_clk_ifc),
    .rst               (rst),
    .ing_beat          (ing_beat),
    .ing_valid         (ing_valid),
    .ing_ready         (ing_ready),
    .egr_beat          (egr_beat),
    .egr_valid         (egr_valid),
    .egr_ready         (egr_ready)
);

// File: tb/phys_port_router_tb.sv
// Self-checking testbench for the echo router with stimulus from a seeded Galois LFSR
// Register accesses are made only while the datapath is idle
module phys_port_router_tb import router_cfg_pkg::*, router_types_pkg::*; ();

    localparam int          TRAFFIC_TIMEOUT = 6000;
    localparam logic [31:0] ALL_PORTS       = 32'((1 << NUM_PORTS) - 1);

    logic                  phys_port_clk_ifc;
    logic                  rst;
    beat_t [NUM_PORTS-1:0] ing_beat;
    logic [NUM_PORTS-1:0]  ing_valid;
    logic [NUM_PORTS-1:0]  ing_ready;
    beat_t [NUM_PORTS-1:0] egr_beat;
    logic [NUM_PORTS-1:0]  egr_valid;
    logic [NUM_PORTS-1:0]  egr_ready;
    reg_req_t              reg_req;
    logic [31:0]           reg_rdata;
    logic                  reg_rvalid;

    logic [15:0]          lfsr_state;
    beat_t                exp_q [NUM_PORTS][$];
    int                   pkts_left [NUM_PORTS];
    int                   beats_left [NUM_PORTS];
    int                   gap [NUM_PORTS];
    int                   ing_pkts [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_on;
    logic                 bp_mode;
    logic                 stalled;
    int                   checks;
    int                   errors;

    phys_port_router u_dut (.*);

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever begin
            #10 phys_port_clk_ifc = ~phys_port_clk_ifc;
        end
    end

    ////////////////////////////////////////
    // Random source and reference model

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Echo mode
    function automatic int expected_port(input int src);
        return src;
    endfunction

    function automatic logic sending_done();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (pkts_left[p] != 0 || beats_left[p] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic datapath_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return egr_valid == '0 && u_dut.fifo_valid == '0;
    endfunction

    ////////////////////////////////////////
    // Stimulus

    task automatic step_cycle();
        logic        xfer;
        logic [31:0] r;
        beat_t       b;
        @(posedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            xfer = ing_valid[p] & ing_ready[p];
            if (xfer) begin
                if (port_on[p]) begin
                    exp_q[expected_port(p)].push_back(ing_beat[p]);
                    if (ing_beat[p].last) begin
                        ing_pkts[p]++;
                    end
                end
                beats_left[p]--;
                r = take_bits(2);
                gap[p] = int'(r[1:0]);
            end
            // A beat not yet taken holds
            if (xfer || !ing_valid[p]) begin
                if (gap[p] > 0) begin
                    gap[p]--;
                    ing_valid[p] <= 1'b0;
                end else if (beats_left[p] == 0 && pkts_left[p] == 0) begin
                    ing_valid[p] <= 1'b0;
                end else begin
                    if (beats_left[p] == 0) begin
                        r = take_bits(4);
                        beats_left[p] = int'(r[3:0]) + 1;
                        pkts_left[p]--;
                    end
                    b.data = take_bits(32);
                    b.last = (beats_left[p] == 1);
                    b.keep = '1;
                    if (b.last) begin
                        r = take_bits(4);
                        b.keep = r[3:0] | 4'b0001;
                    end
                    ing_beat[p]  <= b;
                    ing_valid[p] <= 1'b1;
                end
            end
        end
        r = bp_mode ? take_bits(NUM_PORTS) : ALL_PORTS;
        egr_ready <= r[NUM_PORTS-1:0];
    endtask

    // Runs until every queued packet is sent and the datapath is empty
    task automatic run_traffic(input int pkts_per_port);
        int   n;
        logic done;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkts_left[p] = (pkts_per_port < 0) ? pkts_left[p] : pkts_per_port;
        end
        n    = 0;
        done = 1'b0;
        while (!done && n < TRAFFIC_TIMEOUT) begin
            step_cycle();
            @(negedge phys_port_clk_ifc);
            done = sending_done() && datapath_idle();
            n++;
        end
        if (!done) begin
            errors++;
            stalled = 1'b1;
            $display("Traffic did not drain within %0d cycles", TRAFFIC_TIMEOUT);
        end
    endtask

    task automatic reg_write(input int addr, input logic [31:0] data);
        @(posedge phys_port_clk_ifc);
        reg_req <= '{rd: 1'b0, wr: 1'b1, addr: REG_ADDR_WIDTH'(addr), wdata: data};
        @(posedge phys_port_clk_ifc);
        reg_req <= '0;
        if (addr == REG_ENABLE_ADDR) begin
            port_on = data[NUM_PORTS-1:0];
        end
    endtask

    task automatic reg_check(input int addr, input logic [31:0] expected);
        @(posedge phys_port_clk_ifc);
        reg_req <= '{rd: 1'b1, wr: 1'b0, addr: REG_ADDR_WIDTH'(addr), wdata: '0};
        @(posedge phys_port_clk_ifc);
        reg_req <= '0;
        checks++;
        assert (!reg_rvalid) else begin
            errors++;
            $display("Read of register %0d responded in the same cycle as the request", addr);
        end
        @(posedge phys_port_clk_ifc);
        checks++;
        assert (reg_rvalid) else begin
            errors++;
            $display("Read of register %0d gave no response one cycle after the request", addr);
        end
        checks++;
        assert (!reg_rvalid || reg_rdata == expected) else begin
            errors++;
            $display("Mismatch at %0t: register %0d read %h, expected %h",
                     $time, addr, reg_rdata, expected);
        end
    endtask

    ////////////////////////////////////////
    // Egress compare

    initial begin
        beat_t want;
        forever begin
            @(posedge phys_port_clk_ifc);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!rst && egr_valid[p] && egr_ready[p]) begin
                    checks++;
                    assert (exp_q[p].size() > 0) else begin
                        errors++;
                        $display("Unexpected beat on egress port %0d at time %0t", p, $time);
                    end
                    if (exp_q[p].size() > 0) begin
                        want = exp_q[p].pop_front();
                        checks++;
                        assert (egr_beat[p] == want) else begin
                            errors++;
                            $display("Mismatch at %0t: egress port %0d got %h, expected %h",
                                     $time, p, egr_beat[p], want);
                        end
                    end
                end
            end
        end
    end

    initial begin
        lfsr_state = 16'd97;
        checks     = 0;
        errors     = 0;
        stalled    = 1'b0;
        bp_mode    = 1'b0;
        port_on    = '1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkts_left[p]  = 0;
            beats_left[p] = 0;
            gap[p]        = 0;
            ing_pkts[p]   = 0;
        end
        rst       <= 1'b1;
        ing_beat  <= '0;
        ing_valid <= '0;
        egr_ready <= '1;
        reg_req   <= '0;
        repeat (8) @(posedge phys_port_clk_ifc);
        rst <= 1'b0;
        @(posedge phys_port_clk_ifc);

        checks++;
        assert (egr_valid == '0) else begin
            errors++;
            $display("Mismatch at %0t: egr_valid is %b after reset, expected 0",
                     $time, egr_valid);
        end
        checks++;
        assert (ing_ready == '1) else begin
            errors++;
            $display("Mismatch at %0t: ing_ready is %b after reset, expected all ones",
                     $time, ing_ready);
        end
        reg_check(REG_ENABLE_ADDR, ALL_PORTS);
        for (int p = 0; p < NUM_PORTS; p++) begin
            reg_check(REG_ING_CNT_BASE + p, 32'd0);
            reg_check(REG_EGR_CNT_BASE + p, 32'd0);
        end

        run_traffic(6);
        if (!stalled) begin
            bp_mode = 1'b1;
            run_traffic(6);
            bp_mode = 1'b0;
        end
        // Only port 2 sends while it is disabled
        if (!stalled) begin
            reg_write(REG_ENABLE_ADDR, ALL_PORTS & ~(32'd1 << 2));
            reg_check(REG_ENABLE_ADDR, ALL_PORTS & ~(32'd1 << 2));
            pkts_left[2] = 4;
            run_traffic(-1);
        end
        if (!stalled) begin
            reg_write(REG_ENABLE_ADDR, ALL_PORTS);
            run_traffic(4);
        end
        if (!stalled) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                reg_check(REG_ING_CNT_BASE + p, 32'(ing_pkts[p]));
                reg_check(REG_EGR_CNT_BASE + p, 32'(ing_pkts[p]));
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: phys_port_router.f
hw/router_cfg_pkg.sv
hw/router_types_pkg.sv
hw/beat_fifo.sv
hw/packet_arbiter.sv
hw/egress_demux.sv
hw/router_regs.sv
hw/phys_port_router.sv
tb/phys_port_router_sva.sv
tb/phys_port_router_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the router testbench with Verilator, runs it and checks the result
set -u
cd "$(dirname "$0")" || exit 1

TOP=phys_port_router_tb
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" --Mdir "$BUILD_DIR" \
    -f phys_port_router.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
